/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module tb_msx_core -f list.f
	@out="$$(./obj_dir/Vtb_msx_core)"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

/* list.f */
rtl/msx_pkg.sv
rtl/io_decoder.sv
rtl/ppi_ports.sv
rtl/m1_wait.sv
rtl/audio_mixer.sv
rtl/msx_core.sv
tb/msx_checker.sv
tb/tb_msx_core.sv

/* rtl/audio_mixer.sv */
module audio_mixer import msx_pkg::*; (
   input  logic                      clk21m,
   input  logic                      exwait_n,
   input  logic [PSG_W-1:0]          psg_i,
   input  logic                      keybeep_i,
   input  logic                      cas_audio_i,
   input  logic                      cas_motor_i,
   input  logic signed [AUDIO_W-1:0] dev_sound_i,
   output logic [AUDIO_W-1:0]        audio_o
);

   logic [PSG_W-1:0]   psg_sum;
   logic [PSG_W-1:0]   beep_part;
   logic [PSG_W-1:0]   cas_part;
   logic [MIX_W-1:0]   psg_ext;
   logic [MIX_W-1:0]   dev_ext;
   logic [MIX_W-1:0]   mix;
   logic [AUDIO_W-1:0] sat;

   // Key click weighs 32, tape input 16 while the motor is off
   assign beep_part = PSG_W'(keybeep_i) << 5;
   assign cas_part  = PSG_W'(cas_audio_i & ~cas_motor_i) << 4;
   assign psg_sum   = psg_i + beep_part + cas_part;

   assign psg_ext = MIX_W'({psg_sum, 4'b0000});
   assign dev_ext = {{(MIX_W-AUDIO_W){dev_sound_i[AUDIO_W-1]}}, dev_sound_i};
   assign mix     = psg_ext + dev_ext;

   // Clip on the top three bits
   always_comb begin
      case (mix[MIX_W-1 -: 3])
         3'b000:                 sat = {1'b0, mix[MIX_W-4:0], 1'b0};
         3'b111:                 sat = {1'b1, mix[MIX_W-4:0], 1'b0};
         3'b001, 3'b010, 3'b011: sat = AUDIO_MAX;
         default:                sat = AUDIO_MIN;
      endcase
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n)
         audio_o <= '0;
      else
         audio_o <= sat;
   end

endmodule

/* rtl/io_decoder.sv */
module io_decoder import msx_pkg::*; (
   input  cpu_bus_t bus_i,
   output io_sel_t  sel_o
);

   logic io_cycle;
   logic [4:0] port_hi;

   // Plain I/O cycle only, interrupt acknowledge has m1 set
   assign io_cycle = bus_i.iorq & ~bus_i.m1;
   assign port_hi  = bus_i.addr[7:3];

   always_comb begin
      sel_o.psg = io_cycle & (port_hi == PSG_PORT);
      sel_o.ppi = io_cycle & (port_hi == PPI_PORT);
      sel_o.vdp = io_cycle & (port_hi == VDP_PORT);
   end

endmodule

/* rtl/m1_wait.sv */
module m1_wait (
   input  logic clk21m,
   input  logic exwait_n,
   input  logic ce_i,
   input  logic m1_i,
   output logic wait_n_o
);

   logic m1_prev;
   logic m1_start;

   // Rising m1 seen across two enable samples
   assign m1_start = m1_i & ~m1_prev;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         m1_prev  <= 1'b0;
         wait_n_o <= 1'b1;
      end else if (ce_i) begin
         m1_prev  <= m1_i;
         // Low for one enable period, then released
         wait_n_o <= ~m1_start;
      end
   end

endmodule

/* rtl/msx_core.sv */
module msx_core import msx_pkg::*; (
   input  logic                      clk21m,
   input  logic                      exwait_n,
   input  logic                      ce_3m58_p_i,
   input  cpu_bus_t                  bus_i,
   input  logic [7:0]                kb_col_i,
   input  logic [7:0]                psg_data_i,
   input  logic [7:0]                vdp_data_i,
   input  logic [7:0]                mem_data_i,
   input  logic                      cas_audio_i,
   input  logic [PSG_W-1:0]          psg_sound_i,
   input  logic signed [AUDIO_W-1:0] dev_sound_i,
   output logic [7:0]                cpu_data_o,
   output logic [1:0]                slot_o,
   output logic [3:0]                kb_row_o,
   output logic                      cas_motor_o,
   output logic                      wait_n_o,
   output logic [AUDIO_W-1:0]        audio_o
);

   io_sel_t    io_sel;
   logic [7:0] ppi_data;
   logic       keybeep;

   io_decoder i_io_decoder (
      .bus_i (bus_i),
      .sel_o (io_sel)
   );

   ppi_ports i_ppi_ports (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .bus_i       (bus_i),
      .ppi_sel_i   (io_sel.ppi),
      .kb_col_i    (kb_col_i),
      .rd_data_o   (ppi_data),
      .slot_o      (slot_o),
      .kb_row_o    (kb_row_o),
      .cas_motor_o (cas_motor_o),
      .keybeep_o   (keybeep)
   );

   m1_wait i_m1_wait (
      .clk21m   (clk21m),
      .exwait_n (exwait_n),
      .ce_i     (ce_3m58_p_i),
      .m1_i     (bus_i.m1),
      .wait_n_o (wait_n_o)
   );

   audio_mixer i_audio_mixer (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .psg_i       (psg_sound_i),
      .keybeep_i   (keybeep),
      .cas_audio_i (cas_audio_i),
      .cas_motor_i (cas_motor_o),
      .dev_sound_i (dev_sound_i),
      .audio_o     (audio_o)
   );

   // Read data back to the CPU, first match wins
   always_comb begin
      if (!bus_i.rd)
         cpu_data_o = 8'hFF;
      else if (io_sel.vdp)
         cpu_data_o = vdp_data_i;
      else if (io_sel.psg)
         cpu_data_o = psg_data_i;
      else if (io_sel.ppi)
         cpu_data_o = ppi_data;
      else if (bus_i.iorq)
         cpu_data_o = 8'hFF;   // unmapped port or interrupt acknowledge
      else
         cpu_data_o = mem_data_i;
   end

endmodule

/* rtl/msx_pkg.sv */
package msx_pkg;

   // One sample of the Z80 bus, strobes active high
   typedef struct packed {
      logic        mreq;
      logic        iorq;
      logic        rd;
      logic        wr;
      logic        m1;
      logic [15:0] addr;
      logic [7:0]  data;
   } cpu_bus_t;

   // I/O device selects
   typedef struct packed {
      logic psg;
      logic ppi;
      logic vdp;
   } io_sel_t;

   // Upper I/O address bits 7..3 of each device
   localparam logic [4:0] PSG_PORT = 5'b10100;
   localparam logic [4:0] PPI_PORT = 5'b10101;
   localparam logic [4:0] VDP_PORT = 5'b10011;

   // PPI control register index
   localparam logic [1:0] PPI_CTRL = 2'd3;

   // Audio path widths
   localparam int PSG_W   = 10;
   localparam int MIX_W   = 17;
   localparam int AUDIO_W = 16;

   // Saturation limits of the output
   localparam logic [AUDIO_W-1:0] AUDIO_MAX = 16'h7FFF;
   localparam logic [AUDIO_W-1:0] AUDIO_MIN = 16'h8000;

endpackage

/* rtl/ppi_ports.sv */
module ppi_ports import msx_pkg::*; (
   input  logic       clk21m,
   input  logic       exwait_n,
   input  cpu_bus_t   bus_i,
   input  logic       ppi_sel_i,
   input  logic [7:0] kb_col_i,
   output logic [7:0] rd_data_o,
   output logic [1:0] slot_o,
   output logic [3:0] kb_row_o,
   output logic       cas_motor_o,
   output logic       keybeep_o
);

   logic [7:0] port_a;
   logic [7:0] port_c;
   logic [1:0] idx;
   logic       wr_done;
   logic       wr_en;
   logic       map_valid;

   assign idx = bus_i.addr[1:0];

   // One write per wr strobe
   assign wr_en = ppi_sel_i & bus_i.wr & ~wr_done;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a    <= '0;
         port_c    <= '0;
         wr_done   <= 1'b0;
         map_valid <= 1'b0;
      end else begin
         if (ppi_sel_i)
            map_valid <= 1'b1;
         if (!bus_i.wr)
            wr_done <= 1'b0;
         else if (ppi_sel_i)
            wr_done <= 1'b1;
         if (wr_en) begin
            case (idx)
               2'd0: port_a <= bus_i.data;
               2'd2: port_c <= bus_i.data;
               PPI_CTRL: begin
                  // Bit set/reset; mode words have bit 7 set
                  if (!bus_i.data[7])
                     port_c[bus_i.data[3:1]] <= bus_i.data[0];
               end
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (idx)
         2'd0:    rd_data_o = port_a;
         2'd1:    rd_data_o = kb_col_i;
         2'd2:    rd_data_o = port_c;
         default: rd_data_o = 8'hFF;
      endcase
   end

   // Slot pair for the current 16K page
   always_comb begin
      if (!map_valid)
         slot_o = 2'b00;
      else
         slot_o = port_a[{bus_i.addr[15:14], 1'b0} +: 2];
   end

   assign kb_row_o    = port_c[3:0];
   assign cas_motor_o = port_c[4];
   assign keybeep_o   = port_c[7];

endmodule

/* tb/msx_checker.sv */
module msx_checker import msx_pkg::*; (
   input  logic                      clk21m,
   input  logic                      exwait_n,
   input  cpu_bus_t                  bus_i,
   input  logic [7:0]                kb_col_i,
   input  logic [7:0]                psg_data_i,
   input  logic [7:0]                vdp_data_i,
   input  logic [7:0]                mem_data_i,
   input  logic                      cas_audio_i,
   input  logic [PSG_W-1:0]          psg_sound_i,
   input  logic signed [AUDIO_W-1:0] dev_sound_i,
   input  logic [7:0]                cpu_data_i,
   input  logic [1:0]                slot_i,
   input  logic [3:0]                kb_row_i,
   input  logic                      cas_motor_i,
   input  logic                      wait_n_i,
   input  logic [AUDIO_W-1:0]        audio_i,
   input  logic [2:0]                test_id_i,
   input  logic                      test_end_i,
   input  logic                      all_done_i,
   output int                        err_cnt_o
);

   // Enable period of the CPU clock in clk21m cycles
   localparam int CE_DIV = 6;

   logic [7:0]  m_port_a;
   logic [7:0]  m_port_c;
   logic        m_map_valid;
   logic [15:0] exp_audio;
   logic        exp_audio_ok;
   logic        m1_was;
   int          m1_low;
   int errors = 0;
   int checks = 0;
   int test_errs = 0;
   int test_checks = 0;
   int tests_run = 0;
   int tests_failed = 0;

   assign err_cnt_o = errors;

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd0:    return "slot_select";
         3'd1:    return "ppi_readback";
         3'd2:    return "control_register";
         3'd3:    return "read_mux";
         3'd4:    return "audio_mix";
         default: return "m1_wait";
      endcase
   endfunction

   // Sum, scale by 16, add device sound, then clip on the top three of 17 bits
   function automatic logic [15:0] audio_model(input logic [PSG_W-1:0] psg,
                                               input logic beep, input logic tape,
                                               input logic signed [15:0] dev);
      int sum;
      int mix;
      int top;
      sum = (int'(psg) + (beep ? 32 : 0) + (tape ? 16 : 0)) % 1024;
      mix = (sum * 16 + int'(dev)) & 'h1FFFF;
      top = mix >> 14;
      if (top == 0)
         return 16'((mix & 'h3FFF) << 1);
      if (top == 7)
         return 16'h8000 | 16'((mix & 'h3FFF) << 1);
      if (top < 4)
         return 16'h7FFF;
      return 16'h8000;
   endfunction

   task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      test_checks++;
      if (exp !== act) begin
         errors++;
         test_errs++;
         $display("MISMATCH %s %s: expected %h actual %h",
                  test_name(test_id_i), what, exp, act);
      end
   endtask

   always @(posedge clk21m) begin : watch
      logic       io_ok;
      logic [7:0] exp_data;
      logic [7:0] ppi_rd;
      logic [1:0] exp_slot;
      if (!exwait_n) begin
         m_port_a     = '0;
         m_port_c     = '0;
         m_map_valid  = 1'b0;
         exp_audio_ok = 1'b0;
         m1_was       = 1'b0;
         m1_low       = 0;
      end else begin
         io_ok = bus_i.iorq && !bus_i.m1;
         case (bus_i.addr[1:0])
            2'd0:    ppi_rd = m_port_a;
            2'd1:    ppi_rd = kb_col_i;
            2'd2:    ppi_rd = m_port_c;
            default: ppi_rd = 8'hFF;
         endcase
         if (!bus_i.rd)
            exp_data = 8'hFF;
         else if (io_ok && bus_i.addr[7:3] == VDP_PORT)
            exp_data = vdp_data_i;
         else if (io_ok && bus_i.addr[7:3] == PSG_PORT)
            exp_data = psg_data_i;
         else if (io_ok && bus_i.addr[7:3] == PPI_PORT)
            exp_data = ppi_rd;
         else if (bus_i.iorq)
            exp_data = 8'hFF;
         else
            exp_data = mem_data_i;
         compare("cpu_data_o", 16'(exp_data), 16'(cpu_data_i));

         exp_slot = m_map_valid ? 2'(m_port_a >> (2 * int'(bus_i.addr[15:14]))) : 2'd0;
         compare("slot_o", 16'(exp_slot), 16'(slot_i));
         compare("kb_row_o", 16'(m_port_c[3:0]), 16'(kb_row_i));
         compare("cas_motor_o", 16'(m_port_c[4]), 16'(cas_motor_i));

         // Registered output lags its inputs by one clock
         if (exp_audio_ok)
            compare("audio_o", exp_audio, audio_i);
         exp_audio = audio_model(psg_sound_i, m_port_c[7], cas_audio_i & ~m_port_c[4],
                                 dev_sound_i);
         exp_audio_ok = 1'b1;

         if (bus_i.m1) begin
            if (!wait_n_i)
               m1_low++;
         end else begin
            if (!wait_n_i) begin
               errors++;
               test_errs++;
               $display("ERROR %s: wait_n_o is low outside an M1 cycle",
                        test_name(test_id_i));
            end
            if (m1_was)
               compare("wait_n_o low cycles", 16'(CE_DIV), 16'(m1_low));
            m1_low = 0;
         end
         m1_was = bus_i.m1;

         // Model state moves after this edge's comparisons
         if (io_ok && bus_i.addr[7:3] == PPI_PORT) begin
            m_map_valid = 1'b1;
            if (bus_i.wr) begin
               case (bus_i.addr[1:0])
                  2'd0: m_port_a = bus_i.data;
                  2'd2: m_port_c = bus_i.data;
                  2'd3: begin
                     if (!bus_i.data[7])
                        m_port_c[bus_i.data[3:1]] = bus_i.data[0];
                  end
                  default: ;
               endcase
            end
         end
      end

      if (test_end_i) begin
         tests_run++;
         if (test_errs != 0)
            tests_failed++;
         $display("test %s: %s, %0d checks, %0d errors", test_name(test_id_i),
                  (test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
         test_errs   = 0;
         test_checks = 0;
      end
      if (all_done_i)
         $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                  tests_run, tests_failed, checks, errors);
   end

endmodule

/* tb/tb_msx_core.sv */
module tb_msx_core import msx_pkg::*; ();

   localparam int CLK_PERIOD = 20;
   localparam int CE_DIV     = 6;
   // Bus cycles per test in run order
   localparam int TOTAL_CYCLES = (4 + 12 * 5) + 16 * 5 + 32 * 2 + 48 + 16 * 2 + 24;

   logic                      clk21m = 1'b0;
   logic                      exwait_n;
   logic [2:0]                ce_div = '0;
   logic                      ce_3m58;
   cpu_bus_t                  bus;
   logic [7:0]                kb_col;
   logic [7:0]                psg_data;
   logic [7:0]                vdp_data;
   logic [7:0]                mem_data;
   logic                      cas_audio;
   logic [PSG_W-1:0]          psg_sound;
   logic signed [AUDIO_W-1:0] dev_sound;
   logic [7:0]                cpu_data;
   logic [1:0]                slot;
   logic [3:0]                kb_row;
   logic                      cas_motor;
   logic                      wait_n;
   logic [AUDIO_W-1:0]        audio;
   logic [2:0]                test_id;
   logic                      test_end;
   logic                      all_done;
   int                        err_cnt;
   int                        tb_errs;
   integer                    seed = 32'hd5a2;

   msx_core i_msx_core (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .ce_3m58_p_i (ce_3m58),
      .bus_i       (bus),
      .kb_col_i    (kb_col),
      .psg_data_i  (psg_data),
      .vdp_data_i  (vdp_data),
      .mem_data_i  (mem_data),
      .cas_audio_i (cas_audio),
      .psg_sound_i (psg_sound),
      .dev_sound_i (dev_sound),
      .cpu_data_o  (cpu_data),
      .slot_o      (slot),
      .kb_row_o    (kb_row),
      .cas_motor_o (cas_motor),
      .wait_n_o    (wait_n),
      .audio_o     (audio)
   );

   msx_checker i_msx_checker (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .bus_i       (bus),
      .kb_col_i    (kb_col),
      .psg_data_i  (psg_data),
      .vdp_data_i  (vdp_data),
      .mem_data_i  (mem_data),
      .cas_audio_i (cas_audio),
      .psg_sound_i (psg_sound),
      .dev_sound_i (dev_sound),
      .cpu_data_i  (cpu_data),
      .slot_i      (slot),
      .kb_row_i    (kb_row),
      .cas_motor_i (cas_motor),
      .wait_n_i    (wait_n),
      .audio_i     (audio),
      .test_id_i   (test_id),
      .test_end_i  (test_end),
      .all_done_i  (all_done),
      .err_cnt_o   (err_cnt)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk21m = ~clk21m;
   end

   // CPU clock enable on one clk21m in six
   always @(negedge clk21m)
      ce_div <= (ce_div == 3'(CE_DIV - 1)) ? 3'd0 : ce_div + 3'd1;
   assign ce_3m58 = (ce_div == 3'(CE_DIV - 1));

   initial begin
      #(TOTAL_CYCLES * 40 * CLK_PERIOD);
      $display("ERROR: watchdog timeout, the tests did not finish in time");
      $display("RESULT: FAIL");
      $finish;
   end

   // Next falling edge with fresh data on the free-running inputs
   task automatic step();
      @(negedge clk21m);
      kb_col    = 8'($random(seed));
      psg_data  = 8'($random(seed));
      vdp_data  = 8'($random(seed));
      mem_data  = 8'($random(seed));
      cas_audio = 1'($random(seed));
      psg_sound = PSG_W'($random(seed));
      dev_sound = AUDIO_W'($random(seed));
   endtask

   task automatic drive(input cpu_bus_t b);
      bus = b;
      repeat (3) step();
      bus = {5'b0, bus.addr, bus.data};
      step();
   endtask

   function automatic logic [7:0] ppi_addr(input logic [1:0] idx);
      return {PPI_PORT, 1'($random(seed)), idx};
   endfunction

   task automatic io_cycle(input logic [7:0] port, input logic wr, input logic [7:0] data);
      cpu_bus_t b;
      b      = '0;
      b.iorq = 1'b1;
      b.rd   = ~wr;
      b.wr   = wr;
      b.addr = {8'($random(seed)), port};
      b.data = data;
      drive(b);
   endtask

   task automatic mem_read();
      cpu_bus_t b;
      b      = '0;
      b.mreq = 1'b1;
      b.rd   = 1'b1;
      b.addr = 16'($random(seed));
      drive(b);
   endtask

   // Opcode fetch or interrupt acknowledge when inta is set
   task automatic m1_cycle(input logic inta);
      int guard;
      bus      = '0;
      bus.m1   = 1'b1;
      bus.rd   = 1'b1;
      bus.mreq = ~inta;
      bus.iorq = inta;
      bus.addr = 16'($random(seed));
      guard    = 0;
      while (wait_n && guard < 4 * CE_DIV) begin
         step();
         guard++;
      end
      if (wait_n) begin
         tb_errs++;
         $display("ERROR: wait_n_o never went low during an M1 cycle");
      end
      guard = 0;
      while (!wait_n && guard < 4 * CE_DIV) begin
         step();
         guard++;
      end
      if (!wait_n) begin
         tb_errs++;
         $display("ERROR: wait_n_o stayed low during an M1 cycle");
      end
      bus = {5'b0, bus.addr, bus.data};
      repeat (CE_DIV + 1) step();
   endtask

   task automatic end_test();
      test_end = 1'b1;
      step();
      test_end = 1'b0;
   endtask

   initial begin
      logic [2:0] kind;
      bus       = '0;
      kb_col    = '0;
      psg_data  = '0;
      vdp_data  = '0;
      mem_data  = '0;
      cas_audio = 1'b0;
      psg_sound = '0;
      dev_sound = '0;
      test_id   = 3'd0;
      test_end  = 1'b0;
      all_done  = 1'b0;
      tb_errs   = 0;
      exwait_n  = 1'b0;
      repeat (8) step();
      exwait_n = 1'b1;

      // Memory reads before the first PPI access see slot 0
      repeat (4) mem_read();
      repeat (12) begin
         io_cycle(ppi_addr(2'd0), 1'b1, 8'($random(seed)));
         repeat (4) mem_read();
      end
      end_test();

      test_id = 3'd1;
      repeat (16) begin
         io_cycle(ppi_addr(2'd0), 1'b1, 8'($random(seed)));
         io_cycle(ppi_addr(2'd0), 1'b0, 8'h00);
         io_cycle(ppi_addr(2'd2), 1'b1, 8'($random(seed)));
         io_cycle(ppi_addr(2'd2), 1'b0, 8'h00);
         io_cycle(ppi_addr(2'd1), 1'b0, 8'h00);
      end
      end_test();

      // Random data gives both bit set/reset and mode words
      test_id = 3'd2;
      repeat (32) begin
         io_cycle(ppi_addr(PPI_CTRL), 1'b1, 8'($random(seed)));
         io_cycle(ppi_addr(2'd2), 1'b0, 8'h00);
      end
      end_test();

      test_id = 3'd3;
      repeat (48) begin
         kind = 3'($random(seed));
         case (kind)
            3'd0:    io_cycle({PSG_PORT, 3'($random(seed))}, 1'b0, 8'h00);
            3'd1:    io_cycle({VDP_PORT, 3'($random(seed))}, 1'b0, 8'h00);
            3'd2:    io_cycle(ppi_addr(2'($random(seed))), 1'b0, 8'h00);
            3'd3:    io_cycle(8'($random(seed)), 1'b0, 8'h00);
            3'd4:    mem_read();
            3'd5:    mem_read();
            default: m1_cycle(1'b1);
         endcase
      end
      end_test();

      // Port C writes set the key click and motor states
      test_id = 3'd4;
      repeat (16) begin
         io_cycle(ppi_addr(2'd2), 1'b1, 8'($random(seed)));
         repeat (10) step();
      end
      end_test();

      test_id = 3'd5;
      repeat (24) begin
         kind = 3'($random(seed));
         m1_cycle(kind == 3'd0);
      end
      end_test();

      all_done = 1'b1;
      step();
      all_done = 1'b0;
      step();
      if (err_cnt == 0 && tb_errs == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
